// ==== sim.f ====
bf16_pkg.sv
bf16_operands_if.sv
bf16_partial_if.sv
bf16_unpack.sv
wallace_mant_mul.sv
bf16_normalize_pack.sv
bf16_mul_top.sv
tb_bf16_mul.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -f sim.f --top-module tb_bf16_mul

# the exit status of the pipe is that of tee, the log decides
./obj_dir/Vtb_bf16_mul 2>&1 | tee sim.log

if grep -q "TESTS PASSED" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

// ==== tb_bf16_mul.sv ====
`timescale 1ns/100ps

module tb_bf16_mul import bf16_pkg::*; ();

  localparam int TIMEOUT_CYCLES = 3000;
  localparam int LATENCY        = 3;
  localparam int NUM_RANDOM     = 1500;
  localparam int NUM_EDGE       = 60;
  localparam int NUM_GAPPED     = 150;

  logic        clk;
  logic        rst_n;
  logic        in_valid;
  logic [15:0] a;
  logic [15:0] b;
  logic        out_valid;
  logic [15:0] result;
  fp_status_e  status;

  // expected {status, result} and the cycle of the sampling edge
  logic [17:0] exp_q[$];
  int          ts_q[$];
  int          cycle;

  bf16_mul_top i_bf16_mul_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .a         (a),
    .b         (b),
    .out_valid (out_valid),
    .result    (result),
    .status    (status)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic stop_with_error(input string line);
    $display("%s", line);
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped on error");
  endtask

  // expected {status, result} from the format rules
  function automatic logic [17:0] ref_mul(input logic [15:0] x, input logic [15:0] y);
    int   ex;
    int   ey;
    int   fx;
    int   fy;
    int   prod;
    int   e;
    int   fr;
    logic s;
    logic x_nan;
    logic x_inf;
    logic x_zero;
    logic y_nan;
    logic y_inf;
    logic y_zero;
    ex     = int'(x[14:7]);
    ey     = int'(y[14:7]);
    fx     = int'(x[6:0]);
    fy     = int'(y[6:0]);
    s      = x[15] ^ y[15];
    x_nan  = (ex == 255) && (fx != 0);
    x_inf  = (ex == 255) && (fx == 0);
    x_zero = (ex == 0);
    y_nan  = (ey == 255) && (fy != 0);
    y_inf  = (ey == 255) && (fy == 0);
    y_zero = (ey == 0);
    if (x_nan || y_nan || (x_inf && y_zero) || (x_zero && y_inf)) begin
      return {2'd2, 16'h7FC0};
    end
    if (x_inf || y_inf) begin
      return {2'd1, s, 8'hFF, 7'h00};
    end
    if (x_zero || y_zero) begin
      return {2'd0, s, 15'h0000};
    end
    prod = (128 + fx) * (128 + fy);
    e    = ex + ey - 127;
    // truncation keeps the seven bits below the leading one
    if (prod >= 32768) begin
      fr = (prod >> 8) % 128;
      e  = e + 1;
    end else begin
      fr = (prod >> 7) % 128;
    end
    if (e >= 255) begin
      return {2'd1, s, 8'hFF, 7'h00};
    end
    if (e <= 0) begin
      return {2'd0, s, 15'h0000};
    end
    return {2'd3, s, e[7:0], fr[6:0]};
  endfunction

  function automatic logic [15:0] make_op(input logic s, input int e, input int f);
    return {s, 8'(e), 7'(f)};
  endfunction

  function automatic int clamp_exp(input int e);
    if (e < 1) begin
      return 1;
    end
    if (e > 254) begin
      return 254;
    end
    return e;
  endfunction

  function automatic logic [15:0] rand_normal();
    logic [31:0] r;
    int          e;
    r = $urandom();
    e = 1 + int'($urandom_range(253));
    return make_op(r[15], e, int'(r[6:0]));
  endfunction

  task automatic drive_pair(input logic [15:0] x, input logic [15:0] y);
    in_valid = 1'b1;
    a        = x;
    b        = y;
    exp_q.push_back(ref_mul(x, y));
    ts_q.push_back(cycle + 1);
    @(posedge clk);
    #1;
  endtask

  task automatic idle(input int n);
    in_valid = 1'b0;
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= TIMEOUT_CYCLES) begin
      stop_with_error($sformatf("timeout: run did not finish within %0d cycles",
                                TIMEOUT_CYCLES));
    end
  end

  // outputs are sampled on the falling edge
  // and taken by a consumer at the next rising edge
  always @(negedge clk) begin
    logic [17:0] expv;
    int          ts;
    int          lat;
    if (out_valid === 1'b1) begin
      assert (exp_q.size() > 0) else
        stop_with_error("out_valid arrived with no pending input");
      expv = exp_q.pop_front();
      ts   = ts_q.pop_front();
      lat  = cycle + 1 - ts;
      assert (lat == LATENCY) else
        stop_with_error($sformatf("[FAIL] %0t out_valid latency expected %0d got %0d",
                                  $time, LATENCY, lat));
      assert (result === expv[15:0]) else
        stop_with_error($sformatf("[FAIL] %0t result expected %h got %h",
                                  $time, expv[15:0], result));
      assert (status === fp_status_e'(expv[17:16])) else
        stop_with_error($sformatf("[FAIL] %0t status expected %0d got %0d",
                                  $time, expv[17:16], status));
    end
  end

  initial begin
    int          ex;
    int          ey;
    logic [31:0] r;
    rst_n    = 1'b1;
    in_valid = 1'b0;
    a        = 16'h0000;
    b        = 16'h0000;
    cycle    = 0;
    void'($urandom(32'h782a));
    #1;
    rst_n = 1'b0;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    assert (out_valid === 1'b0) else
      stop_with_error("out_valid is not low after reset");

    // NaN operands and inf times zero
    drive_pair(16'h7FC1, 16'h3F80);
    drive_pair(16'h4040, 16'hFFFF);
    drive_pair(16'h7F80, 16'h0000);
    drive_pair(16'h8000, 16'hFF80);
    drive_pair(16'h7F80, 16'h0001);
    // inf and zero classes with subnormals as zero
    drive_pair(16'h7F80, 16'hC000);
    drive_pair(16'h3F80, 16'hFF80);
    drive_pair(16'h8000, 16'h4000);
    drive_pair(16'h0005, 16'hC000);
    drive_pair(16'h3F80, 16'h807F);
    // exact values and both range edges
    drive_pair(16'h3F80, 16'h3F80);
    drive_pair(16'h3FC0, 16'hBFC0);
    drive_pair(16'h7F7F, 16'h7F7F);
    drive_pair(16'h0080, 16'h0080);

    // back-to-back random normal pairs
    for (int i = 0; i < NUM_RANDOM; i++) begin
      drive_pair(rand_normal(), rand_normal());
    end

    // exponent sums close to overflow
    for (int i = 0; i < NUM_EDGE; i++) begin
      r  = $urandom();
      ex = 127 + int'($urandom_range(127));
      ey = clamp_exp(381 - ex + int'($urandom_range(3)) - 2);
      drive_pair(make_op(r[15], ex, int'(r[6:0])), make_op(r[14], ey, int'(r[13:7])));
    end

    // exponent sums close to underflow
    for (int i = 0; i < NUM_EDGE; i++) begin
      r  = $urandom();
      ex = 1 + int'($urandom_range(125));
      ey = clamp_exp(127 - ex + int'($urandom_range(3)) - 1);
      drive_pair(make_op(r[15], ex, int'(r[6:0])), make_op(r[14], ey, int'(r[13:7])));
    end

    // strobes with random gaps
    for (int i = 0; i < NUM_GAPPED; i++) begin
      idle(int'($urandom_range(3)));
      drive_pair(rand_normal(), rand_normal());
    end

    idle(LATENCY + 3);
    assert (exp_q.size() == 0) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      stop_with_error($sformatf("%0d expected results never came out", exp_q.size()));
    end
  end

endmodule

// ==== bf16_mul_top.sv ====
`timescale 1ns/100ps

module bf16_mul_top import bf16_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        in_valid,
  input  logic [15:0] a,
  input  logic [15:0] b,
  output logic        out_valid,
  output logic [15:0] result,
  output fp_status_e  status
);

  // unpack to tree
  bf16_operands_if ops_if ();

  // tree to normalize
  bf16_partial_if part_if ();

  bf16_unpack i_unpack (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .a        (a),
    .b        (b),
    .ops      (ops_if.src)
  );

  wallace_mant_mul i_wallace (
    .clk   (clk),
    .rst_n (rst_n),
    .ops   (ops_if.dst),
    .part  (part_if.src)
  );

  bf16_normalize_pack i_norm_pack (
    .clk       (clk),
    .rst_n     (rst_n),
    .part      (part_if.dst),
    .out_valid (out_valid),
    .result    (result),
    .status    (status)
  );

endmodule

// ==== bf16_normalize_pack.sv ====
`timescale 1ns/100ps

module bf16_normalize_pack import bf16_pkg::*; (
  input  logic         clk,
  input  logic         rst_n,
  bf16_partial_if.dst  part,
  output logic         out_valid,
  output logic [15:0]  result,
  output fp_status_e   status
);

  logic [PROD_W-1:0]        prod;
  logic                     norm_shift;
  logic [FRAC_W-1:0]        frac;
  logic signed [ESUM_W-1:0] exp_adj;
  logic [15:0]              inf_word;
  logic [15:0]              zero_word;
  logic [15:0]              res_d;
  fp_status_e               stat_d;

  // final carry-propagate add, product of two normal mantissas is in [2^14, 2^16)
  assign prod       = part.sum_row + part.carry_row;
  assign norm_shift = prod[PROD_W-1];

  // truncation, low product bits are dropped
  assign frac    = norm_shift ? prod[PROD_W-2 -: FRAC_W] : prod[PROD_W-3 -: FRAC_W];
  assign exp_adj = part.exp_sum + ESUM_W'(norm_shift);

  assign inf_word  = {part.sign, EXP_W'(EXP_MAX), {FRAC_W{1'b0}}};
  assign zero_word = {part.sign, {(EXP_W + FRAC_W){1'b0}}};

  always_comb begin
    case (part.special)
      FP_NAN: begin
        res_d  = QNAN;
        stat_d = FP_NAN;
      end
      FP_INF: begin
        res_d  = inf_word;
        stat_d = FP_INF;
      end
      FP_ZERO: begin
        res_d  = zero_word;
        stat_d = FP_ZERO;
      end
      default: begin
        if (exp_adj >= EXP_MAX) begin
          res_d  = inf_word;
          stat_d = FP_INF;
        end else if (exp_adj <= 0) begin
          // underflow flushes to signed zero
          res_d  = zero_word;
          stat_d = FP_ZERO;
        end else begin
          res_d  = {part.sign, exp_adj[EXP_W-1:0], frac};
          stat_d = FP_VALID;
        end
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= part.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (part.valid) begin
      result <= res_d;
      status <= stat_d;
    end
  end

endmodule

// ==== wallace_mant_mul.sv ====
`timescale 1ns/100ps

module wallace_mant_mul import bf16_pkg::*; (
  input  logic          clk,
  input  logic          rst_n,
  bf16_operands_if.dst  ops,
  bf16_partial_if.src   part
);

  // one row of 3:2 cells, result packed as {carry, sum}
  // in edge columns one input is zero and the cell acts as a half adder
  function automatic logic [2*PROD_W-1:0] fa_row(
    input logic [PROD_W-1:0] x,
    input logic [PROD_W-1:0] y,
    input logic [PROD_W-1:0] z
  );
    logic [PROD_W-1:0] s;
    logic [PROD_W-1:0] c;
    s = x ^ y ^ z;
    c = ((x & y) | (x & z) | (y & z)) << 1;
    return {c, s};
  endfunction

  logic [PROD_W-1:0] pp [MANT_W];

  logic [PROD_W-1:0] s1a;
  logic [PROD_W-1:0] c1a;
  logic [PROD_W-1:0] s1b;
  logic [PROD_W-1:0] c1b;
  logic [PROD_W-1:0] s2a;
  logic [PROD_W-1:0] c2a;
  logic [PROD_W-1:0] s2b;
  logic [PROD_W-1:0] c2b;
  logic [PROD_W-1:0] s3;
  logic [PROD_W-1:0] c3;
  logic [PROD_W-1:0] s4;
  logic [PROD_W-1:0] c4;

  // 64 partial-product bits, row i shifted left by i
  always_comb begin
    for (int i = 0; i < MANT_W; i++) begin
      pp[i] = PROD_W'(ops.mant_a & {MANT_W{ops.mant_b[i]}}) << i;
    end
  end

  // stage 1, 8 rows down to 6
  assign {c1a, s1a} = fa_row(pp[0], pp[1], pp[2]);
  assign {c1b, s1b} = fa_row(pp[3], pp[4], pp[5]);

  // stage 2, 6 rows down to 4
  assign {c2a, s2a} = fa_row(s1a, c1a, s1b);
  assign {c2b, s2b} = fa_row(c1b, pp[6], pp[7]);

  // stage 3, 4 rows down to 3, c2b waits a stage
  assign {c3, s3} = fa_row(s2a, c2a, s2b);

  // stage 4, last two rows
  assign {c4, s4} = fa_row(s3, c3, c2b);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      part.valid <= 1'b0;
    end else begin
      part.valid <= ops.valid;
    end
  end

  // side info travels with the rows
  always_ff @(posedge clk) begin
    if (ops.valid) begin
      part.sign      <= ops.sign;
      part.exp_sum   <= ops.exp_sum;
      part.special   <= ops.special;
      part.sum_row   <= s4;
      part.carry_row <= c4;
    end
  end

endmodule

// ==== bf16_unpack.sv ====
`timescale 1ns/100ps

module bf16_unpack import bf16_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        in_valid,
  input  logic [15:0] a,
  input  logic [15:0] b,
  bf16_operands_if.src ops
);

  logic [EXP_W-1:0]         exp_a;
  logic [EXP_W-1:0]         exp_b;
  logic                     a_nan;
  logic                     a_inf;
  logic                     a_zero;
  logic                     b_nan;
  logic                     b_inf;
  logic                     b_zero;
  logic signed [ESUM_W-1:0] esum;
  fp_status_e               cls;

  assign exp_a = a[FRAC_W +: EXP_W];
  assign exp_b = b[FRAC_W +: EXP_W];

  // subnormals fall into the zero class
  assign a_nan  = (exp_a == EXP_W'(EXP_MAX)) && (a[FRAC_W-1:0] != '0);
  assign a_inf  = (exp_a == EXP_W'(EXP_MAX)) && (a[FRAC_W-1:0] == '0);
  assign a_zero = (exp_a == '0);
  assign b_nan  = (exp_b == EXP_W'(EXP_MAX)) && (b[FRAC_W-1:0] != '0);
  assign b_inf  = (exp_b == EXP_W'(EXP_MAX)) && (b[FRAC_W-1:0] == '0);
  assign b_zero = (exp_b == '0);

  always_comb begin
    if (a_nan || b_nan || (a_inf && b_zero) || (a_zero && b_inf)) begin
      cls = FP_NAN;
    end else if (a_inf || b_inf) begin
      cls = FP_INF;
    end else if (a_zero || b_zero) begin
      cls = FP_ZERO;
    end else begin
      cls = FP_VALID;
    end
  end

  // biased sum, stays in range for any pair of 8-bit exponents
  assign esum = ESUM_W'(exp_a) + ESUM_W'(exp_b) - ESUM_W'(EXP_BIAS);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ops.valid <= 1'b0;
    end else begin
      ops.valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      ops.sign    <= a[15] ^ b[15];
      ops.exp_sum <= esum;
      ops.mant_a  <= {1'b1, a[FRAC_W-1:0]};
      ops.mant_b  <= {1'b1, b[FRAC_W-1:0]};
      ops.special <= cls;
    end
  end

endmodule

// ==== bf16_partial_if.sv ====
`timescale 1ns/100ps

interface bf16_partial_if import bf16_pkg::*; ();

  logic                     valid;
  logic                     sign;
  logic signed [ESUM_W-1:0] exp_sum;
  fp_status_e               special;
  // carry-save form of the mantissa product
  logic [PROD_W-1:0]        sum_row;
  logic [PROD_W-1:0]        carry_row;

  modport src (
    output valid, sign, exp_sum, special, sum_row, carry_row
  );

  modport dst (
    input valid, sign, exp_sum, special, sum_row, carry_row
  );

endinterface

// ==== bf16_operands_if.sv ====
`timescale 1ns/100ps

interface bf16_operands_if import bf16_pkg::*; ();

  logic                     valid;
  logic                     sign;
  logic signed [ESUM_W-1:0] exp_sum;
  logic [MANT_W-1:0]        mant_a;
  logic [MANT_W-1:0]        mant_b;
  // operand class after priority, FP_VALID when both are normal
  fp_status_e               special;

  modport src (
    output valid, sign, exp_sum, mant_a, mant_b, special
  );

  modport dst (
    input valid, sign, exp_sum, mant_a, mant_b, special
  );

endinterface

// ==== bf16_pkg.sv ====
package bf16_pkg;

  // bfloat16 field widths
  localparam int EXP_W  = 8;
  localparam int FRAC_W = 7;

  // mantissa with the hidden one, and the full mantissa product
  localparam int MANT_W = FRAC_W + 1;
  localparam int PROD_W = 2 * MANT_W;

  localparam int EXP_BIAS = 127;
  localparam int EXP_MAX  = 255;

  // signed exponent sum, wide enough for 254 + 254 - 127 and for 1 + 1 - 127
  localparam int ESUM_W = 10;

  // every NaN result uses this one quiet encoding
  localparam logic [15:0] QNAN = 16'h7FC0;

  // status codes seen at the output
  typedef enum logic [1:0] {
    FP_ZERO  = 2'd0,
    FP_INF   = 2'd1,
    FP_NAN   = 2'd2,
    FP_VALID = 2'd3
  } fp_status_e;

endpackage
